//--- tests/conv_patterns.txt
// Word layout tag_ch1_ch0 in hex, tag 0 is an input pixel and tag 1 an expected output pixel
// Frames are row-major, first frame inputs then its results, then the second frame
0_64_04
0_64_08
0_64_0C
0_64_10
0_64_04
0_64_08
0_64_0C
0_64_10
0_9C_04
0_9C_08
0_9C_0C
0_9C_10
0_9C_04
0_9C_08
0_9C_0C
0_9C_10
1_7F_12
1_7F_22
1_7F_32
1_7F_2E
1_7F_16
1_7F_2A
1_7F_3E
1_7F_39
1_80_16
1_80_2A
1_80_3E
1_80_39
1_80_10
1_80_20
1_80_30
1_80_31
0_04_00
0_04_00
0_04_00
0_04_00
0_04_00
0_04_00
0_04_FB
0_04_00
0_04_00
0_04_00
0_04_00
0_04_00
0_04_00
0_04_00
0_04_00
0_04_00
1_0E_00
1_10_FD
1_10_FD
1_0C_00
1_11_00
1_14_FD
1_14_F6
1_0F_FD
1_11_00
1_14_FE
1_14_FD
1_0F_FE
1_0D_00
1_10_00
1_10_00
1_0D_00

//--- channelwiseConvolution.f
+incdir+common
common/pixelStreamIf.sv
common/convPkg.sv
design/constantPadding.sv
slidingWindow/slidingWindow.sv
design/windowAccumulator.sv
design/channelwiseConvolution.sv
tests/channelwiseConvolution_assert.sv
tests/channelwiseConvolution_tb.sv

//--- run.sh
#!/bin/bash
# Build the testbench with Verilator, run it, and look for the pass line in its output
verilator --binary --timing --assert \
    --top-module channelwiseConvolution_tb \
    -f channelwiseConvolution.f \
    -o channelwiseConvolution_sim \
    && ./obj_dir/channelwiseConvolution_sim | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run failed"; exit 1; }

//--- tests/channelwiseConvolution_tb.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module channelwiseConvolution_tb
    import convPkg::*;
();

    localparam int PatternLines = 64;
    localparam int FramePixels = `CONV_IN_HEIGHT * `CONV_IN_WIDTH;
    localparam int TimeoutCycles = 40 * PatternLines;
    localparam int IdleCycles = 10;
    localparam int DrainCycles = 20;

    // Top border rows and the first left border pixel come before the first body pixel
    localparam int LeadingBorder = (`CONV_IN_WIDTH + 2 * `CONV_PAD) * `CONV_PAD + `CONV_PAD;

    logic  clock_i;
    logic  rst_i;
    logic  inValid_i;
    logic  inReady_o;
    pixelT inData_i;
    logic  inLast_i;
    logic  outValid_o;
    logic  outReady_i;
    pixelT outData_o;
    logic  outLast_o;

    // Each word is a tag nibble, then channel 1, then channel 0
    logic [19:0] patternMem [PatternLines];
    pixelT       inputPixels [$];
    pixelT       expectedPixels [$];
    logic [15:0] lfsrState;
    int          cycleCount;
    int          outCount;
    int          dataErrors;
    int          lastErrors;
    int          otherErrors;

    channelwiseConvolution uut (
        .clock_i    (clock_i),
        .rst_i      (rst_i),
        .inValid_i  (inValid_i),
        .inReady_o  (inReady_o),
        .inData_i   (inData_i),
        .inLast_i   (inLast_i),
        .outValid_o (outValid_o),
        .outReady_i (outReady_i),
        .outData_o  (outData_o),
        .outLast_o  (outLast_o)
    );

    initial begin
        clock_i = 1'b0;
        forever #10 clock_i = ~clock_i;
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] stepLfsr(logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // Tag 0 marks an input pixel and tag 1 an expected output pixel
    task automatic splitPatterns();
        logic [19:0] line;
        for (int i = 0; i < PatternLines; i++) begin
            line = patternMem[i];
            if ($isunknown(line)) begin
                $display("Pattern line %0d is missing or unreadable", i);
                otherErrors++;
            end else if (line[19:16] == 4'h0) begin
                inputPixels.push_back(pixelT'(line[15:0]));
            end else if (line[19:16] == 4'h1) begin
                expectedPixels.push_back(pixelT'(line[15:0]));
            end else begin
                $display("Pattern line %0d has an unknown tag %h", i, line[19:16]);
                otherErrors++;
            end
        end
    endtask

    task automatic checkOutput(pixelT got, logic gotLast);
        pixelT expected;
        logic  expectedLast;
        expected = expectedPixels[outCount];
        expectedLast = (outCount + 1) % FramePixels == 0;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            if (got[ch] !== expected[ch]) begin
                $display("mismatch at %0t: output %0d channel %0d expected %h, got %h",
                         $time, outCount, ch, expected[ch], got[ch]);
                dataErrors++;
            end
        end
        if (gotLast !== expectedLast) begin
            $display("mismatch at %0t: output %0d has last %b, expected %b",
                     $time, outCount, gotLast, expectedLast);
            lastErrors++;
        end
        outCount++;
    endtask

    initial begin
        int   inIndex;
        logic inTaken;
        logic outTaken;
        logic timedOut;
        logic expectedReady;
        rst_i = 1'b1;
        inValid_i = 1'b0;
        inData_i = '0;
        inLast_i = 1'b0;
        outReady_i = 1'b0;
        lfsrState = 16'd49060;
        cycleCount = 0;
        outCount = 0;
        dataErrors = 0;
        lastErrors = 0;
        otherErrors = 0;
        inIndex = 0;
        inTaken = 1'b0;
        outTaken = 1'b0;
        timedOut = 1'b0;
        expectedReady = 1'b0;

        $readmemh("tests/conv_patterns.txt", patternMem);
        splitPatterns();
        if (inputPixels.size() != 2 * FramePixels
            || expectedPixels.size() != 2 * FramePixels) begin
            $display("Pattern file does not hold two full frames of inputs and results");
            otherErrors++;
        end

        repeat (4) @(posedge clock_i);
        @(negedge clock_i);
        rst_i = 1'b0;
        outReady_i = 1'b1;

        // Border pixels flow right after reset, yet no window can complete without input.
        // The input is held off until the leading border pixels have left the padder
        for (int i = 1; i <= IdleCycles; i++) begin
            @(posedge clock_i);
            cycleCount++;
            expectedReady = i > LeadingBorder;
            if (outValid_o) begin
                $display("Output became valid before any input pixel was sent");
                otherErrors++;
            end
            if (inReady_o !== expectedReady) begin
                $display("mismatch at %0t: inReady_o is %b in idle cycle %0d, expected %b",
                         $time, inReady_o, i, expectedReady);
                otherErrors++;
            end
        end

        while (outCount < expectedPixels.size() && !timedOut) begin
            @(negedge clock_i);
            lfsrState = stepLfsr(lfsrState);
            outReady_i = lfsrState[0];
            if (inTaken) begin
                inValid_i = 1'b0;
            end
            // A new pixel is offered only after the previous one was taken
            if (!inValid_i && inIndex < inputPixels.size()) begin
                lfsrState = stepLfsr(lfsrState);
                if (lfsrState[0]) begin
                    inValid_i = 1'b1;
                    inData_i = inputPixels[inIndex];
                    inLast_i = (inIndex + 1) % FramePixels == 0;
                end
            end

            @(posedge clock_i);
            cycleCount++;
            inTaken = inValid_i && inReady_o;
            outTaken = outValid_o && outReady_i;
            if (inTaken) begin
                inIndex++;
            end
            if (outTaken) begin
                checkOutput(outData_o, outLast_o);
            end
            if (cycleCount >= TimeoutCycles) begin
                $display("Timeout: only %0d of %0d outputs arrived within %0d cycles",
                         outCount, expectedPixels.size(), TimeoutCycles);
                otherErrors++;
                timedOut = 1'b1;
            end
        end

        @(negedge clock_i);
        inValid_i = 1'b0;
        outReady_i = 1'b1;

        // Anything still coming out would be a duplicate
        if (!timedOut) begin
            repeat (DrainCycles) begin
                @(posedge clock_i);
                if (outValid_o) begin
                    $display("Output produced beyond the expected %0d pixels", outCount);
                    otherErrors++;
                end
            end
        end

        $display("Error counts: data %0d, frame end %0d, other %0d",
                 dataErrors, lastErrors, otherErrors);
        if (dataErrors + lastErrors + otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tests/channelwiseConvolution_assert.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module channelwiseConvolution_assert
    import convPkg::*;
#(
    parameter bit CheckPosition = 1'b0
) (
    input logic  clock_i,
    input logic  rst_i,
    input logic  inValid_i,
    input logic  inReady_i,
    input logic  inLast_i,
    input logic  finalPosition_i,
    input logic  outValid_i,
    input logic  outReady_i,
    input pixelT outData_i,
    input logic  outLast_i
);

    logic       inTransfer;
    logic       outTransfer;
    logic [3:0] pendingLast;

    assign inTransfer = inValid_i && inReady_i;
    assign outTransfer = outValid_i && outReady_i;

    // Frame ends taken at the input that have not left at the output yet
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            pendingLast <= '0;
        end else if (inTransfer && inLast_i && !(outTransfer && outLast_i)) begin
            pendingLast <= pendingLast + 1'b1;
        end else if (outTransfer && outLast_i && !(inTransfer && inLast_i)) begin
            pendingLast <= pendingLast - 1'b1;
        end
    end

    holdUntilReady: assert property (@(posedge clock_i) disable iff (rst_i)
        outValid_i && !outReady_i |=> outValid_i && $stable(outData_i) && $stable(outLast_i))
        else $error("Output valid dropped or data changed while ready was low");

    validLowAfterReset: assert property (@(posedge clock_i)
        rst_i |=> !outValid_i)
        else $error("Output valid is high in the cycle after reset");

    lastFollowsInput: assert property (@(posedge clock_i) disable iff (rst_i)
        outTransfer && outLast_i |-> pendingLast != 0)
        else $error("Output carries last without a matching input frame end");

    lastAtFinalPosition: assert property (@(posedge clock_i) disable iff (rst_i)
        CheckPosition && inTransfer |-> inLast_i == finalPosition_i)
        else $error("Input last does not match the final pixel position of the frame");

endmodule

// Padder output register, checked against its own row and column counters
bind constantPadding channelwiseConvolution_assert #(
    .CheckPosition(1'b1)
) padderChecks (
    .clock_i         (clock_i),
    .rst_i           (rst_i),
    .inValid_i       (inValid_i),
    .inReady_i       (inReady_o),
    .inLast_i        (inLast_i),
    .finalPosition_i (int'(row) == `CONV_PAD + `CONV_IN_HEIGHT - 1
                      && int'(col) == `CONV_PAD + `CONV_IN_WIDTH - 1),
    .outValid_i      (validReg),
    .outReady_i      (canLoad),
    .outData_i       (dataReg),
    .outLast_i       (lastReg)
);

bind windowAccumulator channelwiseConvolution_assert #(
    .CheckPosition(1'b0)
) accumulatorChecks (
    .clock_i         (clock_i),
    .rst_i           (rst_i),
    .inValid_i       (window.valid),
    .inReady_i       (stage1Enable),
    .inLast_i        (window.last),
    .finalPosition_i (1'b0),
    .outValid_i      (outValid_o),
    .outReady_i      (outReady_i),
    .outData_i       (outData_o),
    .outLast_i       (outLast_o)
);

//--- design/channelwiseConvolution.sv
`timescale 1ns/100ps

module channelwiseConvolution
    import convPkg::*;
(
    input  logic  clock_i,
    input  logic  rst_i,
    input  logic  inValid_i,
    output logic  inReady_o,
    input  pixelT inData_i,
    input  logic  inLast_i,
    output logic  outValid_o,
    input  logic  outReady_i,
    output pixelT outData_o,
    output logic  outLast_o
);

    // Padded pixels on their way to the line buffers
    pixelStreamIf #(.DataWidth($bits(pixelT))) paddedStream ();

    // Complete 3x3 windows on their way to the multiply-accumulate stages
    pixelStreamIf #(.DataWidth($bits(windowT))) windowStream ();

    constantPadding padderInst (
        .clock_i   (clock_i),
        .rst_i     (rst_i),
        .inValid_i (inValid_i),
        .inReady_o (inReady_o),
        .inData_i  (inData_i),
        .inLast_i  (inLast_i),
        .padded    (paddedStream.source)
    );

    slidingWindow windowInst (
        .clock_i (clock_i),
        .rst_i   (rst_i),
        .padded  (paddedStream.sink),
        .window  (windowStream.source)
    );

    windowAccumulator accumulatorInst (
        .clock_i    (clock_i),
        .rst_i      (rst_i),
        .window     (windowStream.sink),
        .outValid_o (outValid_o),
        .outReady_i (outReady_i),
        .outData_o  (outData_o),
        .outLast_o  (outLast_o)
    );

endmodule

//--- design/windowAccumulator.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module windowAccumulator
    import convPkg::*;
(
    input  logic       clock_i,
    input  logic       rst_i,
    pixelStreamIf.sink window,
    output logic       outValid_o,
    input  logic       outReady_i,
    output pixelT      outData_o,
    output logic       outLast_o
);

    localparam int KernelSize = `CONV_KERNEL_SIZE;
    localparam int KernelArea = KernelSize * KernelSize;
    localparam sumT MaxActivation = sumT'((1 << (`CONV_ACT_WIDTH - 1)) - 1);
    localparam sumT MinActivation = sumT'(-(1 << (`CONV_ACT_WIDTH - 1)));

    windowT windowIn;
    sumT    products [`CONV_CHANNELS][KernelArea];
    sumT    treeSums [`CONV_CHANNELS];
    sumT    sums [`CONV_CHANNELS];
    logic   stage1Valid;
    logic   stage1Last;
    logic   stage2Valid;
    logic   stage2Last;
    logic   stage1Enable;
    logic   stage2Enable;

    function automatic activationT shiftAndClip(sumT value);
        sumT shifted;
        shifted = value >>> `CONV_RIGHT_SHIFT;
        if (shifted > MaxActivation) begin
            return activationT'(MaxActivation);
        end else if (shifted < MinActivation) begin
            return activationT'(MinActivation);
        end
        return activationT'(shifted);
    endfunction

    assign windowIn = windowT'(window.data);

    // A stage loads when it is empty or its contents move on in the same cycle
    assign stage2Enable = !stage2Valid || outReady_i;
    assign stage1Enable = !stage1Valid || stage2Enable;
    assign window.ready = stage1Enable;

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            stage1Valid <= 1'b0;
            stage2Valid <= 1'b0;
        end else begin
            if (stage1Enable) begin
                stage1Valid <= window.valid;
            end
            if (stage2Enable) begin
                stage2Valid <= stage1Valid;
            end
        end
    end

    // Stage one holds every weighted tap of every channel
    always_ff @(posedge clock_i) begin
        if (stage1Enable && window.valid) begin
            for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                for (int r = 0; r < KernelSize; r++) begin
                    for (int c = 0; c < KernelSize; c++) begin
                        products[ch][r * KernelSize + c] <=
                            sumT'(activationT'(windowIn[r][c][ch]))
                            * sumT'(Kernel[r * KernelSize + c]);
                    end
                end
            end
            stage1Last <= window.last;
        end
    end

    always_comb begin
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            treeSums[ch] = '0;
            for (int i = 0; i < KernelArea; i++) begin
                treeSums[ch] = treeSums[ch] + products[ch][i];
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (stage2Enable && stage1Valid) begin
            for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                sums[ch] <= treeSums[ch];
            end
            stage2Last <= stage1Last;
        end
    end

    always_comb begin
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            outData_o[ch] = shiftAndClip(sums[ch]);
        end
    end

    assign outValid_o = stage2Valid;
    assign outLast_o = stage2Last;

endmodule

//--- slidingWindow/slidingWindow.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module slidingWindow
    import convPkg::*;
(
    input  logic         clock_i,
    input  logic         rst_i,
    pixelStreamIf.sink   padded,
    pixelStreamIf.source window
);

    localparam int KernelSize = `CONV_KERNEL_SIZE;
    localparam int PadHeight = `CONV_IN_HEIGHT + 2 * `CONV_PAD;
    localparam int PadWidth = `CONV_IN_WIDTH + 2 * `CONV_PAD;
    localparam int RowBits = $clog2(PadHeight);
    localparam int ColBits = $clog2(PadWidth);

    // Previous padded row and the one before it
    pixelT              lineBufNear [PadWidth];
    pixelT              lineBufFar [PadWidth];
    windowT             windowReg;
    pixelT              inPixel;
    logic [RowBits-1:0] row;
    logic [ColBits-1:0] col;
    logic               lastColumn;
    logic               accept;
    logic               complete;
    logic               validReg;
    logic               lastReg;

    assign inPixel = pixelT'(padded.data);
    assign lastColumn = col == ColBits'(PadWidth - 1);

    // Input stalls while a finished window waits on the consumer
    assign padded.ready = !validReg || window.ready;
    assign accept = padded.valid && padded.ready;

    // With a border of half the kernel the window is full exactly when its centre is
    // inside the original frame
    assign complete = row >= RowBits'(KernelSize - 1) && col >= ColBits'(KernelSize - 1);

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            row <= '0;
            col <= '0;
        end else if (accept) begin
            if (padded.last) begin
                row <= '0;
                col <= '0;
            end else if (lastColumn) begin
                row <= row + 1'b1;
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            validReg <= 1'b0;
        end else if (accept) begin
            validReg <= complete;
        end else if (window.ready) begin
            validReg <= 1'b0;
        end
    end

    // Each accepted pixel shifts the window left by one column and pushes the
    // column above it through the line buffers
    always_ff @(posedge clock_i) begin
        if (accept) begin
            for (int r = 0; r < KernelSize; r++) begin
                for (int c = 0; c < KernelSize - 1; c++) begin
                    windowReg[r][c] <= windowReg[r][c + 1];
                end
            end
            windowReg[0][KernelSize - 1] <= lineBufFar[col];
            windowReg[1][KernelSize - 1] <= lineBufNear[col];
            windowReg[2][KernelSize - 1] <= inPixel;
            lineBufFar[col] <= lineBufNear[col];
            lineBufNear[col] <= inPixel;
            lastReg <= padded.last;
        end
    end

    assign window.valid = validReg;
    assign window.data = windowReg;
    assign window.last = lastReg;

endmodule

//--- design/constantPadding.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module constantPadding
    import convPkg::*;
(
    input  logic         clock_i,
    input  logic         rst_i,
    input  logic         inValid_i,
    output logic         inReady_o,
    input  pixelT        inData_i,
    input  logic         inLast_i,
    pixelStreamIf.source padded
);

    localparam int PadHeight = `CONV_IN_HEIGHT + 2 * `CONV_PAD;
    localparam int PadWidth = `CONV_IN_WIDTH + 2 * `CONV_PAD;
    localparam int RowBits = $clog2(PadHeight);
    localparam int ColBits = $clog2(PadWidth);
    localparam pixelT PadPixel = {`CONV_CHANNELS{activationT'(`CONV_PAD_VALUE)}};

    padStateT           state;
    padStateT           nextRowState;
    logic [RowBits-1:0] row;
    logic [ColBits-1:0] col;
    logic               lastColumn;
    logic               lastRow;
    logic               isBorder;
    logic               canLoad;
    logic               advance;
    logic               validReg;
    logic               lastReg;
    pixelT              dataReg;

    assign lastColumn = col == ColBits'(PadWidth - 1);
    assign lastRow = row == RowBits'(PadHeight - 1);

    // Input pixels only fill the body rows between the left and right borders
    assign isBorder = state != PadBody
        || col < ColBits'(`CONV_PAD)
        || col >= ColBits'(`CONV_PAD + `CONV_IN_WIDTH);

    // The output register can take a new pixel once the current one is gone
    assign canLoad = !validReg || padded.ready;
    assign inReady_o = canLoad && !isBorder;
    assign advance = canLoad && (isBorder || inValid_i);

    // Region of the row that follows the current one
    always_comb begin
        if (lastRow || int'(row) + 1 < `CONV_PAD) begin
            nextRowState = PadTopRow;
        end else if (int'(row) + 1 < `CONV_PAD + `CONV_IN_HEIGHT) begin
            nextRowState = PadBody;
        end else begin
            nextRowState = PadBottomRow;
        end
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            state <= PadTopRow;
            row <= '0;
            col <= '0;
        end else if (advance) begin
            if (lastColumn) begin
                col <= '0;
                row <= lastRow ? '0 : row + 1'b1;
                state <= nextRowState;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            validReg <= 1'b0;
        end else if (advance) begin
            validReg <= 1'b1;
        end else if (padded.ready) begin
            validReg <= 1'b0;
        end
    end

    // Bottom-right border pixel closes the padded frame
    always_ff @(posedge clock_i) begin
        if (advance) begin
            dataReg <= isBorder ? PadPixel : inData_i;
            lastReg <= lastRow && lastColumn;
        end
    end

    assign padded.valid = validReg;
    assign padded.data = dataReg;
    assign padded.last = lastReg;

endmodule

//--- common/convPkg.sv
`include "conv_params.svh"

package convPkg;

    // Signed activation word carried by each channel
    typedef logic signed [`CONV_ACT_WIDTH-1:0] activationT;

    typedef logic signed [`CONV_WEIGHT_WIDTH-1:0] weightT;

    // Wide enough for nine products of activation and weight
    typedef logic signed [`CONV_SUM_WIDTH-1:0] sumT;

    // One activation per channel, channel 0 in the low bits
    typedef activationT [`CONV_CHANNELS-1:0] pixelT;

    // Window indexed as [row][column], row 0 is the top row
    typedef pixelT [`CONV_KERNEL_SIZE-1:0][`CONV_KERNEL_SIZE-1:0] windowT;

    // Padder position within the padded frame
    typedef enum logic [1:0] {
        PadTopRow,
        PadBody,
        PadBottomRow
    } padStateT;

    // Kernel shared by every channel, indexed by row * CONV_KERNEL_SIZE + column
    localparam weightT Kernel [`CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE] = '{`CONV_WEIGHTS};

endpackage

//--- common/pixelStreamIf.sv
`timescale 1ns/100ps

// Valid/ready stream with a frame-end marker
interface pixelStreamIf #(
    parameter int DataWidth = 16
) ();

    logic                 valid;
    logic                 ready;
    logic [DataWidth-1:0] data;
    logic                 last;

    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

//--- common/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Channels per pixel and word widths
`define CONV_CHANNELS 2
`define CONV_ACT_WIDTH 8
`define CONV_WEIGHT_WIDTH 8
`define CONV_SUM_WIDTH 20

// Input frame size in pixels
`define CONV_IN_HEIGHT 4
`define CONV_IN_WIDTH 4

// Square kernel, with a border of CONV_PAD pixels on every side
`define CONV_KERNEL_SIZE 3
`define CONV_PAD 1
`define CONV_PAD_VALUE 0

// Arithmetic shift applied to each sum before saturation
`define CONV_RIGHT_SHIFT 2

// Kernel weights in row-major order, top row first
`define CONV_WEIGHTS 1, 2, 1, 2, 8, 2, 0, 2, 2

`endif
